// ==== vlog.f ====
logic/icache_types_pkg.sv
logic/icache_bus_pkg.sv
logic/icache_array.sv
logic/prefetch_buffer.sv
logic/fetch_control.sv
logic/icache_top.sv
tests/sdram_model.sv
tests/icache_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := icache_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
PASS_MSG := Result: PASSED

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/icache_tb.sv ====
`timescale 1ns/10ps

module icache_tb;
    import icache_types_pkg::*;
    import icache_bus_pkg::*;

    localparam int    NUM_SETS     = 8;
    localparam int    NUM_WAYS     = 4;
    localparam int    BLOCK_WORDS  = 4;
    localparam int    CLK_PERIOD   = 10;
    localparam int    SEED         = 13073;
    localparam int    NUM_RANDOM   = 120;
    localparam int    NUM_REQUESTS = 1 + BLOCK_WORDS + 2 + NUM_WAYS + 2 + NUM_RANDOM;
    localparam addr_t BLOCK_BYTES  = addr_t'(BLOCK_WORDS * 4);
    localparam addr_t SET_STRIDE   = addr_t'(NUM_SETS * BLOCK_WORDS * 4);
    localparam addr_t BLOCK_A      = 32'h0000_0100;
    localparam addr_t EVICT_BASE   = 32'h0000_1004;

    logic        Clk;
    logic        rst_n;
    logic        fetch_valid;
    fetch_req_t  fetch_req;
    logic        resp_valid;
    fetch_resp_t fetch_resp;
    logic        busy;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_beat_valid;
    mem_beat_t   mem_beat;

    // Phase flags driven by the stimulus like inputs
    logic expect_fast;
    logic expect_array;
    logic expect_pf;
    logic expect_quiet;

    addr_t  pending[$];
    int     pend_cnt;
    addr_t  head_addr;
    instr_t head_word;
    logic   accepted;
    logic   rst_q;
    logic   acc_q;
    logic   mreq_q;
    logic   fast_acc_q;
    logic   array_acc_q;
    logic   pf_acc_q;
    addr_t  acc_addr_q;

    icache_top #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) i_dut (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .fetch_valid    (fetch_valid),
        .fetch_req      (fetch_req),
        .resp_valid     (resp_valid),
        .fetch_resp     (fetch_resp),
        .busy           (busy),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_beat_valid (mem_beat_valid),
        .mem_beat       (mem_beat)
    );

    sdram_model #(
        .BLOCK_WORDS (BLOCK_WORDS)
    ) i_sdram (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_beat_valid (mem_beat_valid),
        .mem_beat       (mem_beat)
    );

    // Reference memory contents are the address XOR a constant rotated left by 7
    function automatic instr_t expected_word(input addr_t addr);
        instr_t mixed;
        mixed = addr ^ 32'h5A3C_96E1;
        return (mixed << 7) | (mixed >> 25);
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic issue_fetch(input addr_t addr);
        while (busy) begin
            @(posedge Clk);
            #1;
        end
        fetch_valid    = 1'b1;
        fetch_req.addr = addr;
        @(posedge Clk);
        #1;
        fetch_valid = 1'b0;
    endtask

    // Wait until idle with every request answered and any prefetch finished
    task automatic wait_quiet();
        while (busy || mem_req_valid || pend_cnt != 0) begin
            @(posedge Clk);
            #1;
        end
    endtask

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    assign accepted  = fetch_valid && !busy;
    assign head_word = expected_word(head_addr);

    // Scoreboard with one entry per accepted request
    always @(posedge Clk) begin
        if (!rst_n) begin
            pending.delete();
        end else begin
            if (resp_valid && pending.size() > 0) begin
                void'(pending.pop_front());
            end
            if (accepted) begin
                pending.push_back(fetch_req.addr);
            end
        end
        pend_cnt <= pending.size();
        if (pending.size() > 0) begin
            head_addr <= pending[0];
        end
    end

    always @(posedge Clk) begin
        rst_q      <= rst_n;
        acc_addr_q <= fetch_req.addr;
        if (!rst_n) begin
            acc_q       <= 1'b0;
            mreq_q      <= 1'b0;
            fast_acc_q  <= 1'b0;
            array_acc_q <= 1'b0;
            pf_acc_q    <= 1'b0;
        end else begin
            acc_q       <= accepted;
            mreq_q      <= mem_req_valid;
            fast_acc_q  <= accepted && expect_fast;
            array_acc_q <= accepted && expect_array;
            pf_acc_q    <= accepted && expect_pf;
        end
    end

    a_reset_state: assert property (@(posedge Clk)
        (rst_n && !rst_q) |-> (!resp_valid && !mem_req_valid && !busy))
        else report_failure("outputs not idle in the first cycle after reset");

    a_busy_until_answered: assert property (@(posedge Clk) disable iff (!rst_n)
        (pend_cnt != 0 && !resp_valid) |-> busy)
        else report_failure("cache not busy while a request was still unanswered");

    a_resp_has_req: assert property (@(posedge Clk) disable iff (!rst_n)
        resp_valid |-> (pend_cnt != 0))
        else report_failure("response without an outstanding request");

    a_in_order: assert property (@(posedge Clk) disable iff (!rst_n)
        accepted |-> (pend_cnt == 0 || resp_valid))
        else report_failure("request accepted before the previous one was answered");

    a_resp_data: assert property (@(posedge Clk) disable iff (!rst_n)
        (resp_valid && pend_cnt != 0) |-> (fetch_resp.instr == head_word))
        else report_failure($sformatf("MISMATCH at %0t: data %h for address %h, expected %h",
            $time, fetch_resp.instr, head_addr, head_word));

    // A request rising right after acceptance is always the refill
    a_miss_addr: assert property (@(posedge Clk) disable iff (!rst_n)
        (acc_q && mem_req_valid && !mreq_q) |-> (mem_req.addr == acc_addr_q))
        else report_failure($sformatf("MISMATCH at %0t: refill address %h, expected %h",
            $time, mem_req.addr, acc_addr_q));

    a_one_cycle_resp: assert property (@(posedge Clk) disable iff (!rst_n)
        fast_acc_q |-> resp_valid)
        else report_failure("no response one cycle after a request expected to hit");

    a_array_hit: assert property (@(posedge Clk) disable iff (!rst_n)
        array_acc_q |-> !busy)
        else report_failure("cache busy in the response cycle of an expected array hit");

    a_pf_hit: assert property (@(posedge Clk) disable iff (!rst_n)
        pf_acc_q |-> busy)
        else report_failure("no install after an expected prefetch buffer hit");

    a_no_mem_req: assert property (@(posedge Clk) disable iff (!rst_n)
        expect_quiet |-> !mem_req_valid)
        else report_failure("memory request while only hits were expected");

    initial begin
        #(NUM_REQUESTS * 40 * CLK_PERIOD);
        report_failure($sformatf("Timeout: test did not finish within %0d cycles",
            NUM_REQUESTS * 40));
    end

    initial begin
        addr_t addr;
        int    gap;
        void'($urandom(SEED));
        rst_n          = 1'b0;
        fetch_valid    = 1'b0;
        fetch_req      = '0;
        expect_fast    = 1'b0;
        expect_array   = 1'b0;
        expect_pf      = 1'b0;
        expect_quiet   = 1'b0;
        repeat (2) @(posedge Clk);
        #1;
        rst_n = 1'b1;

        // Cold miss on word 2 and the next block then fills the prefetch buffer
        issue_fetch(BLOCK_A + 8);
        wait_quiet();

        expect_quiet = 1'b1;
        expect_fast  = 1'b1;
        expect_array = 1'b1;
        for (int w = 0; w < BLOCK_WORDS; w++) begin
            issue_fetch(BLOCK_A + addr_t'(w * 4));
        end
        expect_array = 1'b0;

        expect_pf = 1'b1;
        issue_fetch(BLOCK_A + BLOCK_BYTES + 4);
        expect_pf = 1'b0;
        wait_quiet();
        expect_array = 1'b1;
        issue_fetch(BLOCK_A + BLOCK_BYTES + 12);
        wait_quiet();
        expect_array = 1'b0;
        expect_fast  = 1'b0;
        expect_quiet = 1'b0;

        // One more block than ways in set 0 and then the first one again
        for (int k = 0; k <= NUM_WAYS; k++) begin
            issue_fetch(EVICT_BASE + addr_t'(k) * SET_STRIDE);
            wait_quiet();
        end
        issue_fetch(EVICT_BASE);
        wait_quiet();

        for (int i = 0; i < NUM_RANDOM; i++) begin
            addr = 32'h0000_4000 + addr_t'($urandom_range(255, 0) * 4);
            issue_fetch(addr);
            gap = $urandom_range(2, 0);
            repeat (gap) begin
                @(posedge Clk);
                #1;
            end
        end
        wait_quiet();

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== tests/sdram_model.sv ====
`timescale 1ns/10ps

module sdram_model #(
    parameter int BLOCK_WORDS = 4
) (
    input  logic                       Clk,
    input  logic                       rst_n,
    input  logic                       mem_req_valid,
    input  icache_bus_pkg::mem_req_t   mem_req,
    output logic                       mem_beat_valid,
    output icache_bus_pkg::mem_beat_t  mem_beat
);
    import icache_types_pkg::*;

    localparam addr_t BLOCK_MASK = addr_t'(BLOCK_WORDS * 4 - 1);

    addr_t start_addr;
    addr_t beat_addr;
    int    idle;
    logic  aborted;

    // Stored contents follow a fixed pattern over the whole word address
    function automatic instr_t word_at(input addr_t addr);
        addr_t x;
        x = addr ^ 32'h5A3C_96E1;
        return {x[24:0], x[31:25]};
    endfunction

    initial begin
        mem_beat_valid = 1'b0;
        mem_beat       = '0;
        forever begin
            @(posedge Clk);
            if (rst_n && mem_req_valid) begin
                start_addr = mem_req.addr;
                aborted    = 1'b0;
                #1;
                for (int n = 0; n < BLOCK_WORDS && !aborted; n++) begin
                    // One to three cycles from the previous point to this beat
                    idle = $urandom_range(2, 0);
                    for (int k = 0; k < idle && !aborted; k++) begin
                        @(posedge Clk);
                        // A request withdrawn before any beat is a cancelled prefetch
                        if (!mem_req_valid) begin
                            aborted = 1'b1;
                        end
                        #1;
                    end
                    if (!aborted) begin
                        // Critical word first, then wrap inside the block
                        beat_addr = (start_addr & ~BLOCK_MASK)
                                  | ((start_addr + addr_t'(n * 4)) & BLOCK_MASK);
                        mem_beat_valid = 1'b1;
                        mem_beat.data  = word_at(beat_addr);
                        @(posedge Clk);
                        #1;
                        mem_beat_valid = 1'b0;
                    end
                end
            end
        end
    end

endmodule

// ==== logic/icache_top.sv ====
`timescale 1ns/10ps

module icache_top #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                         Clk,
    input  logic                         rst_n,
    input  logic                         fetch_valid,
    input  icache_bus_pkg::fetch_req_t   fetch_req,
    output logic                         resp_valid,
    output icache_bus_pkg::fetch_resp_t  fetch_resp,
    output logic                         busy,
    output logic                         mem_req_valid,
    output icache_bus_pkg::mem_req_t     mem_req,
    input  logic                         mem_beat_valid,
    input  icache_bus_pkg::mem_beat_t    mem_beat
);
    import icache_types_pkg::*;

    addr_t                    lookup_addr;
    addr_t                    line_addr;
    addr_t                    pf_addr;
    instr_t                   array_data;
    instr_t                   pf_data;
    instr_t [BLOCK_WORDS-1:0] line_words;
    instr_t [BLOCK_WORDS-1:0] pf_line;
    logic                     array_hit;
    logic                     pf_hit;
    logic                     pf_filling;
    logic                     pf_started;
    logic                     line_write;
    logic                     pf_start;
    logic                     pf_beat_valid;
    logic                     pf_clear;

    icache_array #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) i_array (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .lookup_addr (lookup_addr),
        .array_hit   (array_hit),
        .array_data  (array_data),
        .line_write  (line_write),
        .line_addr   (line_addr),
        .line_words  (line_words)
    );

    // Beat data goes straight to the buffer, the controller gates the strobe
    prefetch_buffer #(
        .BLOCK_WORDS (BLOCK_WORDS)
    ) i_pf_buf (
        .Clk           (Clk),
        .rst_n         (rst_n),
        .pf_start      (pf_start),
        .pf_addr       (pf_addr),
        .pf_beat_valid (pf_beat_valid),
        .pf_beat       (mem_beat),
        .pf_clear      (pf_clear),
        .lookup_addr   (lookup_addr),
        .pf_hit        (pf_hit),
        .pf_data       (pf_data),
        .pf_line       (pf_line),
        .pf_filling    (pf_filling),
        .pf_started    (pf_started)
    );

    fetch_control #(
        .NUM_SETS    (NUM_SETS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) i_ctrl (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .fetch_valid    (fetch_valid),
        .fetch_req      (fetch_req),
        .resp_valid     (resp_valid),
        .fetch_resp     (fetch_resp),
        .busy           (busy),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_beat_valid (mem_beat_valid),
        .mem_beat       (mem_beat),
        .lookup_addr    (lookup_addr),
        .array_hit      (array_hit),
        .array_data     (array_data),
        .pf_hit         (pf_hit),
        .pf_data        (pf_data),
        .pf_line        (pf_line),
        .pf_filling     (pf_filling),
        .pf_started     (pf_started),
        .line_write     (line_write),
        .line_addr      (line_addr),
        .line_words     (line_words),
        .pf_start       (pf_start),
        .pf_addr        (pf_addr),
        .pf_beat_valid  (pf_beat_valid),
        .pf_clear       (pf_clear)
    );

endmodule

// ==== logic/fetch_control.sv ====
`timescale 1ns/10ps

module fetch_control #(
    parameter int NUM_SETS    = 8,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                                         Clk,
    input  logic                                         rst_n,
    input  logic                                         fetch_valid,
    input  icache_bus_pkg::fetch_req_t                   fetch_req,
    output logic                                         resp_valid,
    output icache_bus_pkg::fetch_resp_t                  fetch_resp,
    output logic                                         busy,
    output logic                                         mem_req_valid,
    output icache_bus_pkg::mem_req_t                     mem_req,
    input  logic                                         mem_beat_valid,
    input  icache_bus_pkg::mem_beat_t                    mem_beat,
    output icache_types_pkg::addr_t                      lookup_addr,
    input  logic                                         array_hit,
    input  icache_types_pkg::instr_t                     array_data,
    input  logic                                         pf_hit,
    input  icache_types_pkg::instr_t                     pf_data,
    input  icache_types_pkg::instr_t [BLOCK_WORDS-1:0]   pf_line,
    input  logic                                         pf_filling,
    input  logic                                         pf_started,
    output logic                                         line_write,
    output icache_types_pkg::addr_t                      line_addr,
    output icache_types_pkg::instr_t [BLOCK_WORDS-1:0]   line_words,
    output logic                                         pf_start,
    output icache_types_pkg::addr_t                      pf_addr,
    output logic                                         pf_beat_valid,
    output logic                                         pf_clear
);
    import icache_types_pkg::*;

    localparam int    OFF_W       = $clog2(BLOCK_WORDS) + 2;
    localparam int    CNT_W       = $clog2(BLOCK_WORDS);
    localparam addr_t BLOCK_BYTES = addr_t'(BLOCK_WORDS * 4);

    // Index and offset fields are cut straight out of the address
    if ((NUM_SETS & (NUM_SETS - 1)) != 0 ||
        (BLOCK_WORDS & (BLOCK_WORDS - 1)) != 0) begin : g_geometry_check
        $error("NUM_SETS and BLOCK_WORDS must be powers of two");
    end

    ctrl_state_t              state_q;
    addr_t                    req_addr_q;
    addr_t                    pf_addr_q;
    addr_t                    blk_base;
    instr_t [BLOCK_WORDS-1:0] line_q;
    logic [CNT_W-1:0]         beat_cnt_q;
    logic [CNT_W-1:0]         crit_off;
    logic                     inst_pf_q;
    logic                     crit_resp_q;
    logic                     accept;
    logic                     miss;
    logic                     cancel;
    logic                     issue_miss;
    logic                     refill_beat;
    logic                     refill_last;

    // Busy drops only when idle or when the pending lookup hits the array
    assign busy   = !(state_q == IDLE || (state_q == LOOKUP && array_hit));
    assign accept = fetch_valid && !busy;

    assign lookup_addr = req_addr_q;
    assign crit_off    = req_addr_q[OFF_W-1:2];
    assign blk_base    = {req_addr_q[31:OFF_W], {OFF_W{1'b0}}};

    assign miss        = (state_q == LOOKUP) && !array_hit && !pf_hit;
    // A prefetch that has not delivered a word yet can be dropped
    assign cancel      = miss && pf_filling && !pf_started && !mem_beat_valid;
    assign issue_miss  = miss && !pf_filling;
    assign refill_beat = (state_q == REFILL) && mem_beat_valid;
    assign refill_last = refill_beat && (beat_cnt_q == CNT_W'(BLOCK_WORDS - 1));

    // Array has priority over the prefetch buffer
    assign resp_valid = crit_resp_q || (state_q == LOOKUP && (array_hit || pf_hit));
    always_comb begin
        if (crit_resp_q) begin
            fetch_resp.instr = line_q[crit_off];
        end else if (array_hit) begin
            fetch_resp.instr = array_data;
        end else begin
            fetch_resp.instr = pf_data;
        end
    end

    // Request goes low for the cancel cycle before the miss takes over
    assign mem_req_valid = issue_miss || (state_q == REFILL) || (pf_filling && !cancel);
    assign mem_req.addr  = pf_filling ? pf_addr_q : req_addr_q;

    assign line_write    = (state_q == INSTALL);
    assign line_addr     = blk_base;
    assign line_words    = inst_pf_q ? pf_line : line_q;
    assign pf_start      = line_write && !inst_pf_q;
    assign pf_addr       = blk_base + BLOCK_BYTES;
    assign pf_beat_valid = mem_beat_valid && pf_filling;
    assign pf_clear      = cancel || (line_write && inst_pf_q);

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            inst_pf_q   <= 1'b0;
            crit_resp_q <= 1'b0;
            beat_cnt_q  <= '0;
        end else begin
            crit_resp_q <= refill_beat && (beat_cnt_q == '0);
            if (refill_beat) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    inst_pf_q  <= pf_hit && !array_hit;
                    beat_cnt_q <= '0;
                    if (array_hit) begin
                        state_q <= accept ? LOOKUP : IDLE;
                    end else if (pf_hit) begin
                        state_q <= INSTALL;
                    end else if (issue_miss || cancel) begin
                        state_q <= REFILL;
                    end else begin
                        // Prefetch already under way is left to finish
                        state_q <= PREFETCH;
                    end
                end
                REFILL: begin
                    if (refill_last) begin
                        state_q <= INSTALL;
                    end
                end
                INSTALL: begin
                    state_q <= IDLE;
                end
                PREFETCH: begin
                    // Look again since the wanted word may now be in the buffer
                    if (!pf_filling) begin
                        state_q <= LOOKUP;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            req_addr_q <= fetch_req.addr;
        end
        if (pf_start) begin
            pf_addr_q <= pf_addr;
        end
        // Critical word first, then ascending with wrap inside the block
        if (refill_beat) begin
            line_q[crit_off + beat_cnt_q] <= mem_beat.data;
        end
    end

    a_no_fetch_while_busy: assert property (@(posedge Clk) disable iff (!rst_n)
        fetch_valid |-> !busy)
        else $error("fetch request while busy");

    a_refill_req_stable: assert property (@(posedge Clk) disable iff (!rst_n)
        (issue_miss || (state_q == REFILL && !refill_last))
        |=> mem_req_valid && $stable(mem_req))
        else $error("refill request changed before its last beat");

endmodule

// ==== logic/prefetch_buffer.sv ====
`timescale 1ns/10ps

module prefetch_buffer #(
    parameter int BLOCK_WORDS = 4
) (
    input  logic                                         Clk,
    input  logic                                         rst_n,
    input  logic                                         pf_start,
    input  icache_types_pkg::addr_t                      pf_addr,
    input  logic                                         pf_beat_valid,
    input  icache_bus_pkg::mem_beat_t                    pf_beat,
    input  logic                                         pf_clear,
    input  icache_types_pkg::addr_t                      lookup_addr,
    output logic                                         pf_hit,
    output icache_types_pkg::instr_t                     pf_data,
    output icache_types_pkg::instr_t [BLOCK_WORDS-1:0]   pf_line,
    output logic                                         pf_filling,
    output logic                                         pf_started
);
    localparam int OFF_W = $clog2(BLOCK_WORDS) + 2;
    localparam int CNT_W = $clog2(BLOCK_WORDS);

    logic [31:OFF_W]   blk_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              valid_q;
    logic              take_beat;

    assign take_beat = pf_beat_valid && pf_filling;

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            valid_q    <= 1'b0;
            pf_filling <= 1'b0;
            pf_started <= 1'b0;
            cnt_q      <= '0;
        end else if (pf_start) begin
            valid_q    <= 1'b0;
            pf_filling <= 1'b1;
            pf_started <= 1'b0;
            cnt_q      <= '0;
        end else if (pf_clear) begin
            valid_q    <= 1'b0;
            pf_filling <= 1'b0;
            pf_started <= 1'b0;
        end else if (take_beat) begin
            pf_started <= 1'b1;
            cnt_q      <= cnt_q + 1'b1;
            // Last beat makes the block usable
            if (cnt_q == CNT_W'(BLOCK_WORDS - 1)) begin
                valid_q    <= 1'b1;
                pf_filling <= 1'b0;
            end
        end
    end

    // Prefetch addresses are block aligned, beats come in ascending order
    always_ff @(posedge Clk) begin
        if (pf_start) begin
            blk_q <= pf_addr[31:OFF_W];
        end
        if (take_beat) begin
            pf_line[cnt_q] <= pf_beat.data;
        end
    end

    assign pf_hit  = valid_q && (lookup_addr[31:OFF_W] == blk_q);
    assign pf_data = pf_line[lookup_addr[OFF_W-1:2]];

endmodule

// ==== logic/icache_array.sv ====
`timescale 1ns/10ps

module icache_array #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                                         Clk,
    input  logic                                         rst_n,
    input  icache_types_pkg::addr_t                      lookup_addr,
    output logic                                         array_hit,
    output icache_types_pkg::instr_t                     array_data,
    input  logic                                         line_write,
    input  icache_types_pkg::addr_t                      line_addr,
    input  icache_types_pkg::instr_t [BLOCK_WORDS-1:0]   line_words
);
    import icache_types_pkg::*;

    localparam int OFF_W = $clog2(BLOCK_WORDS) + 2;
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = 32 - IDX_W - OFF_W;
    localparam int WAY_W = $clog2(NUM_WAYS);

    logic [TAG_W-1:0]         tags   [NUM_SETS][NUM_WAYS];
    instr_t [BLOCK_WORDS-1:0] data   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]      valid_q [NUM_SETS];
    logic [WAY_W-1:0]         rr_ptr [NUM_SETS];

    logic [IDX_W-1:0]    rd_idx;
    logic [IDX_W-1:0]    wr_idx;
    logic [TAG_W-1:0]    rd_tag;
    logic [TAG_W-1:0]    wr_tag;
    logic [OFF_W-3:0]    rd_word;
    logic [NUM_WAYS-1:0] way_hit;
    logic [WAY_W-1:0]    hit_way;
    logic [WAY_W-1:0]    fill_way;

    assign rd_idx  = lookup_addr[OFF_W +: IDX_W];
    assign rd_tag  = lookup_addr[31 -: TAG_W];
    assign rd_word = lookup_addr[2 +: OFF_W-2];
    assign wr_idx  = line_addr[OFF_W +: IDX_W];
    assign wr_tag  = line_addr[31 -: TAG_W];

    // Compare every way of the indexed set at once
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[rd_idx][w] && (tags[rd_idx][w] == rd_tag);
            if (way_hit[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    assign array_hit  = |way_hit;
    assign array_data = data[rd_idx][hit_way][rd_word];

    // Lowest invalid way wins, otherwise the set's round-robin pointer
    always_comb begin
        fill_way = rr_ptr[wr_idx];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[wr_idx][w]) begin
                fill_way = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (line_write) begin
            tags[wr_idx][fill_way] <= wr_tag;
            data[wr_idx][fill_way] <= line_words;
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                rr_ptr[s]  <= '0;
            end
        end else if (line_write) begin
            valid_q[wr_idx][fill_way] <= 1'b1;
            if (rr_ptr[wr_idx] == WAY_W'(NUM_WAYS - 1)) begin
                rr_ptr[wr_idx] <= '0;
            end else begin
                rr_ptr[wr_idx] <= rr_ptr[wr_idx] + 1'b1;
            end
        end
    end

    // A block is never installed twice, so a set holds each tag at most once
    a_single_way_hit: assert property (@(posedge Clk) disable iff (!rst_n)
        $onehot0(way_hit))
        else $error("more than one way hit in set %0d", rd_idx);

endmodule

// ==== logic/icache_bus_pkg.sv ====
package icache_bus_pkg;

    // Core to cache request sent with fetch_valid
    typedef struct packed {
        icache_types_pkg::addr_t addr;
    } fetch_req_t;

    // Cache to core response sent with resp_valid
    typedef struct packed {
        icache_types_pkg::instr_t instr;
    } fetch_resp_t;

    // Block read request holding the word address of the first word wanted
    typedef struct packed {
        icache_types_pkg::addr_t addr;
    } mem_req_t;

    // One word returned by the SDRAM controller
    typedef struct packed {
        icache_types_pkg::instr_t data;
    } mem_beat_t;

endpackage

// ==== logic/icache_types_pkg.sv ====
package icache_types_pkg;

    // Byte address on the fetch and memory sides
    typedef logic [31:0] addr_t;

    // Instruction or memory data word
    typedef logic [31:0] instr_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        INSTALL,
        PREFETCH
    } ctrl_state_t;

endpackage
